/* hdl/cache_ctrl.sv */
// cache main controller
`timescale 1ns/1ps

module cache_ctrl #(
    parameter logic [2:0] LFSR_SEED = 3'b111
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   valid,
    input  logic                   op,
    input  cache_pkg::index_t      index,
    input  cache_pkg::tag_t        tag,
    input  cache_pkg::offset_t     offset,
    input  cache_pkg::strb_t       wstrb,
    input  cache_pkg::word_t       wdata,
    output logic                   addr_ok,
    output logic                   data_ok,
    output cache_pkg::word_t       rdata,
    output logic                   rd_req,
    output logic [2:0]             rd_type,
    output cache_pkg::addr_t       rd_addr,
    input  logic                   rd_rdy,
    input  logic                   ret_valid,
    input  logic                   ret_last,
    input  cache_pkg::word_t       ret_data,
    output logic                   wr_req,
    output logic [2:0]             wr_type,
    output cache_pkg::addr_t       wr_addr,
    output cache_pkg::line_t       wr_data,
    input  logic                   wr_rdy,
    input  cache_pkg::tagv_t [1:0] way_tagv,
    input  logic [1:0]             way_dirty,
    input  cache_pkg::line_t [1:0] way_line,
    input  logic                   sbuf_hazard,
    output cache_pkg::index_t      tag_index,
    output logic                   tag_en,
    output logic [1:0]             tag_we,
    output cache_pkg::tagv_t       tag_wdata,
    output logic                   dirty_clear,
    output cache_pkg::way_t        victim,
    output logic                   victim_read,
    output logic                   lookup_en,
    output cache_pkg::bank_t       lookup_bank,
    output logic                   fill_we,
    output cache_pkg::bank_t       fill_bank,
    output cache_pkg::word_t       fill_word,
    output logic                   sbuf_load,
    output cache_pkg::way_t        sbuf_way,
    output cache_pkg::bank_t       sbuf_bank,
    output cache_pkg::index_t      sbuf_index,
    output cache_pkg::strb_t       sbuf_strb,
    output cache_pkg::word_t       sbuf_wdata
);

    cache_pkg::main_state_t state;
    cache_pkg::main_state_t next_state;

    // request buffer
    logic               req_op;
    cache_pkg::tag_t    req_tag;
    cache_pkg::index_t  req_index;
    cache_pkg::offset_t req_offset;
    cache_pkg::strb_t   req_strb;
    cache_pkg::word_t   req_wdata;
    cache_pkg::bank_t   req_bank;

    logic [1:0]         way_hit;
    logic               cache_hit;
    logic               store_hit;
    logic               raw_hazard;
    logic               accept;
    logic               victim_ready;     // victim line valid at the array output
    logic               victim_dirty;
    logic               fill_hit;         // refill beat with the requested word
    logic               write_miss_beat;
    logic [2:0]         lfsr;
    cache_pkg::bank_t   fill_cnt;
    cache_pkg::word_t   strb_mask;
    cache_pkg::word_t   hit_word;

    assign req_bank = req_offset[3:2];

    always_ff @(posedge clk) begin
        if (accept) begin
            req_op     <= op;
            req_tag    <= tag;
            req_index  <= index;
            req_offset <= offset;
            req_strb   <= wstrb;
            req_wdata  <= wdata;
        end
    end

    // tag compare on both ways
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            way_hit[i] = way_tagv[i][0]
                         && (way_tagv[i][$bits(cache_pkg::tagv_t)-1:1] == req_tag);
        end
    end

    assign cache_hit = |way_hit;
    assign store_hit = (state == cache_pkg::lookup) && cache_hit && (req_op == cache_pkg::OP_WRITE);
    assign hit_word  = way_line[way_hit[1]][req_bank*32 +: 32];

    // new read of the very word that is being stored
    assign raw_hazard = store_hit && valid && (op == cache_pkg::OP_READ)
                        && ({tag, index, offset[3:2]} == {req_tag, req_index, req_bank});

    assign addr_ok = ((state == cache_pkg::idle) && !sbuf_hazard)
                     || ((state == cache_pkg::lookup) && cache_hit && !raw_hazard && !sbuf_hazard);
    assign accept  = valid && addr_ok;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= cache_pkg::idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            cache_pkg::idle: begin
                if (accept)
                    next_state = cache_pkg::lookup;
            end
            cache_pkg::lookup: begin
                if (!cache_hit)
                    next_state = cache_pkg::miss;
                else if (!accept)
                    next_state = cache_pkg::idle;
            end
            cache_pkg::miss: begin
                if (victim_ready && (!victim_dirty || wr_rdy))
                    next_state = cache_pkg::replace;
            end
            cache_pkg::replace: begin
                if (rd_rdy)
                    next_state = cache_pkg::refill;
            end
            cache_pkg::refill: begin
                if (ret_valid && ret_last)
                    next_state = cache_pkg::idle;
            end
            default: next_state = cache_pkg::idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            victim_ready <= 1'b0;
            fill_cnt     <= '0;
            lfsr         <= LFSR_SEED;
        end else begin
            victim_ready <= (state == cache_pkg::miss);   // first miss cycle issues the read
            if (fill_we)
                fill_cnt <= fill_cnt + 1'b1;
            if (fill_we && ret_last)
                lfsr <= {lfsr[0], lfsr[2] ^ lfsr[0], lfsr[1]};
        end
    end

    assign victim       = lfsr[0];
    assign victim_dirty = way_dirty[victim] && way_tagv[victim][0];
    assign victim_read  = (state == cache_pkg::miss) || (state == cache_pkg::replace);

    // refill, store bytes merged into the requested word
    assign fill_we   = (state == cache_pkg::refill) && ret_valid;
    assign fill_bank = fill_cnt;
    assign fill_hit  = fill_we && (fill_cnt == req_bank);
    assign strb_mask = {{8{req_strb[3]}}, {8{req_strb[2]}}, {8{req_strb[1]}}, {8{req_strb[0]}}};
    assign write_miss_beat = fill_hit && (req_op == cache_pkg::OP_WRITE);
    assign fill_word = write_miss_beat ? ((req_wdata & strb_mask) | (ret_data & ~strb_mask))
                                       : ret_data;

    assign data_ok = ((state == cache_pkg::lookup) && cache_hit) || fill_hit;
    assign rdata   = (state == cache_pkg::refill) ? ret_data : hit_word;

    assign rd_req  = (state == cache_pkg::replace);
    assign rd_type = cache_pkg::RD_BLOCK;
    assign rd_addr = {req_tag, req_index, {$bits(cache_pkg::offset_t){1'b0}}};

    assign wr_req  = (state == cache_pkg::miss) && victim_ready && victim_dirty;
    assign wr_type = cache_pkg::WR_BLOCK;
    assign wr_addr = {way_tagv[victim][$bits(cache_pkg::tagv_t)-1:1], req_index,
                      {$bits(cache_pkg::offset_t){1'b0}}};
    assign wr_data = way_line[victim];

    // new index while taking requests, buffered index otherwise
    assign tag_index = ((state == cache_pkg::idle) || (state == cache_pkg::lookup)) ? index
                                                                                      : req_index;
    assign tag_en      = accept || fill_hit;
    assign tag_we      = {2{fill_hit}} & {victim, ~victim};
    assign tag_wdata   = {req_tag, 1'b1};
    assign dirty_clear = fill_hit;
    assign lookup_en   = accept;
    assign lookup_bank = offset[3:2];

    // a write miss also goes through the store buffer so the new line ends up dirty
    assign sbuf_load  = store_hit || write_miss_beat;
    assign sbuf_way   = (state == cache_pkg::refill) ? victim : way_hit[1];
    assign sbuf_bank  = req_bank;
    assign sbuf_index = req_index;
    assign sbuf_strb  = req_strb;
    assign sbuf_wdata = req_wdata;

endmodule

/* hdl/cache_pkg.sv */
// data cache shared types
package cache_pkg;

    // address fields of a cpu request
    typedef logic [19:0] tag_t;
    typedef logic [7:0]  index_t;
    typedef logic [3:0]  offset_t;
    typedef logic [1:0]  bank_t;      // word within a line

    localparam int SETS = 1 << $bits(index_t);

    typedef logic [31:0]  word_t;
    typedef logic [3:0]   strb_t;
    typedef logic [127:0] line_t;     // four banks, bank 0 in the low word
    typedef logic [31:0]  addr_t;
    typedef logic         way_t;
    typedef logic [20:0]  tagv_t;     // {tag, valid}

    // cpu op field
    localparam logic OP_READ  = 1'b0;
    localparam logic OP_WRITE = 1'b1;

    // memory request types, whole line only
    localparam logic [2:0] RD_BLOCK = 3'b100;
    localparam logic [2:0] WR_BLOCK = 3'b100;

    typedef enum logic [2:0] {
        idle,
        lookup,
        miss,       // victim read, dirty write-back
        replace,    // refill request
        refill
    } main_state_t;

    typedef enum logic {
        sbuf_idle,
        sbuf_write
    } sbuf_state_t;

endpackage

/* hdl/cache_top.sv */
// two-way data cache top
`timescale 1ns/1ps

module cache_top #(
    parameter logic [2:0] LFSR_SEED = 3'b111
) (
    input  logic               clk,
    input  logic               resetn,
    // cpu side
    input  logic               valid,
    input  logic               op,
    input  cache_pkg::index_t  index,
    input  cache_pkg::tag_t    tag,
    input  cache_pkg::offset_t offset,
    input  cache_pkg::strb_t   wstrb,
    input  cache_pkg::word_t   wdata,
    output logic               addr_ok,
    output logic               data_ok,
    output cache_pkg::word_t   rdata,
    // memory read
    output logic               rd_req,
    output logic [2:0]         rd_type,
    output cache_pkg::addr_t   rd_addr,
    input  logic               rd_rdy,
    input  logic               ret_valid,
    input  logic               ret_last,
    input  cache_pkg::word_t   ret_data,
    // memory write
    output logic               wr_req,
    output logic [2:0]         wr_type,
    output cache_pkg::addr_t   wr_addr,
    output cache_pkg::line_t   wr_data,
    input  logic               wr_rdy
);

    cache_pkg::tagv_t [1:0] way_tagv;
    logic [1:0]             way_dirty;
    cache_pkg::line_t [1:0] way_line;
    cache_pkg::index_t      tag_index;
    logic                   tag_en;
    logic [1:0]             tag_we;
    cache_pkg::tagv_t       tag_wdata;
    logic                   dirty_clear;
    cache_pkg::way_t        victim;
    logic                   victim_read;
    logic                   lookup_en;
    cache_pkg::bank_t       lookup_bank;
    logic                   fill_we;
    cache_pkg::bank_t       fill_bank;
    cache_pkg::word_t       fill_word;

    // store buffer load side
    logic                   sbuf_load;
    cache_pkg::way_t        sbuf_way;
    cache_pkg::bank_t       sbuf_bank;
    cache_pkg::index_t      sbuf_index;
    cache_pkg::strb_t       sbuf_strb;
    cache_pkg::word_t       sbuf_wdata;
    logic                   sbuf_hazard;

    // store buffer write side
    logic                   sb_wr_en;
    cache_pkg::way_t        sb_wr_way;
    cache_pkg::bank_t       sb_wr_bank;
    cache_pkg::index_t      sb_wr_index;
    cache_pkg::strb_t       sb_wr_strb;
    cache_pkg::word_t       sb_wr_data;

    cache_ctrl #(
        .LFSR_SEED(LFSR_SEED)
    ) u_ctrl (
        .clk, .resetn,
        .valid, .op, .index, .tag, .offset, .wstrb, .wdata,
        .addr_ok, .data_ok, .rdata,
        .rd_req, .rd_type, .rd_addr, .rd_rdy, .ret_valid, .ret_last, .ret_data,
        .wr_req, .wr_type, .wr_addr, .wr_data, .wr_rdy,
        .way_tagv, .way_dirty, .way_line, .sbuf_hazard,
        .tag_index, .tag_en, .tag_we, .tag_wdata, .dirty_clear, .victim, .victim_read,
        .lookup_en, .lookup_bank, .fill_we, .fill_bank, .fill_word,
        .sbuf_load, .sbuf_way, .sbuf_bank, .sbuf_index, .sbuf_strb, .sbuf_wdata
    );

    store_buffer u_sbuf (
        .clk, .resetn,
        .load(sbuf_load), .way(sbuf_way), .bank(sbuf_bank), .index(sbuf_index),
        .strb(sbuf_strb), .wdata(sbuf_wdata),
        .req_valid(valid), .req_op(op), .req_bank(offset[3:2]),
        .wr_en(sb_wr_en), .wr_way(sb_wr_way), .wr_bank(sb_wr_bank), .wr_index(sb_wr_index),
        .wr_strb(sb_wr_strb), .wr_data(sb_wr_data), .hazard(sbuf_hazard)
    );

    tagv_array u_tagv (
        .clk, .resetn,
        .index(tag_index), .en(tag_en), .we(tag_we), .wdata(tag_wdata),
        .dirty_set(sb_wr_en), .dirty_way(sb_wr_way), .dirty_index(sb_wr_index),
        .dirty_clear, .clear_way(victim),
        .tagv(way_tagv), .dirty(way_dirty)
    );

    data_array u_data (
        .clk,
        .lookup_en, .lookup_index(tag_index), .lookup_bank,
        .sbuf_en(sb_wr_en), .sbuf_way(sb_wr_way), .sbuf_index(sb_wr_index),
        .sbuf_bank(sb_wr_bank), .sbuf_strb(sb_wr_strb), .sbuf_data(sb_wr_data),
        .fill_en(fill_we), .fill_way(victim), .fill_index(tag_index),
        .fill_bank, .fill_data(fill_word), .victim_read,
        .line(way_line)
    );

endmodule

/* hdl/data_array.sv */
// data banks with port arbiter
`timescale 1ns/1ps

module data_array (
    input  logic                   clk,
    input  logic                   lookup_en,
    input  cache_pkg::index_t      lookup_index,
    input  cache_pkg::bank_t       lookup_bank,
    input  logic                   sbuf_en,
    input  cache_pkg::way_t        sbuf_way,
    input  cache_pkg::index_t      sbuf_index,
    input  cache_pkg::bank_t       sbuf_bank,
    input  cache_pkg::strb_t       sbuf_strb,
    input  cache_pkg::word_t       sbuf_data,
    input  logic                   fill_en,
    input  cache_pkg::way_t        fill_way,
    input  cache_pkg::index_t      fill_index,
    input  cache_pkg::bank_t       fill_bank,
    input  cache_pkg::word_t       fill_data,
    input  logic                   victim_read,
    output cache_pkg::line_t [1:0] line
);

    for (genvar w = 0; w < 2; w++) begin : g_way
        for (genvar b = 0; b < 4; b++) begin : g_bank
            cache_pkg::word_t  ram [cache_pkg::SETS];
            cache_pkg::word_t  rd_q;
            cache_pkg::index_t addr;
            cache_pkg::strb_t  we;
            cache_pkg::word_t  din;
            logic              fill_sel;
            logic              sbuf_sel;
            logic              rd_sel;

            assign fill_sel = fill_en && (fill_way == cache_pkg::way_t'(w))
                              && (fill_bank == cache_pkg::bank_t'(b));
            assign sbuf_sel = sbuf_en && (sbuf_way == cache_pkg::way_t'(w))
                              && (sbuf_bank == cache_pkg::bank_t'(b));
            assign rd_sel   = (victim_read && (fill_way == cache_pkg::way_t'(w)))
                              || (lookup_en && (lookup_bank == cache_pkg::bank_t'(b)));

            // refill wins, then the store buffer, then reads
            always_comb begin
                if (fill_sel) begin
                    addr = fill_index;
                    we   = '1;
                    din  = fill_data;
                end else if (sbuf_sel) begin
                    addr = sbuf_index;
                    we   = sbuf_strb;
                    din  = sbuf_data;
                end else begin
                    addr = lookup_index;    // lookup and victim reads share the read index
                    we   = '0;
                    din  = '0;
                end
            end

            always_ff @(posedge clk) begin
                if (we == '0) begin
                    if (rd_sel)
                        rd_q <= ram[addr];
                end else begin
                    for (int i = 0; i < 4; i++) begin
                        if (we[i])
                            ram[addr][8*i +: 8] <= din[8*i +: 8];
                    end
                end
            end

            assign line[w][32*b +: 32] = rd_q;
        end
    end

endmodule

/* hdl/store_buffer.sv */
// one-entry store buffer
`timescale 1ns/1ps

module store_buffer (
    input  logic              clk,
    input  logic              resetn,
    input  logic              load,
    input  cache_pkg::way_t   way,
    input  cache_pkg::bank_t  bank,
    input  cache_pkg::index_t index,
    input  cache_pkg::strb_t  strb,
    input  cache_pkg::word_t  wdata,
    input  logic              req_valid,
    input  logic              req_op,
    input  cache_pkg::bank_t  req_bank,
    output logic              wr_en,
    output cache_pkg::way_t   wr_way,
    output cache_pkg::bank_t  wr_bank,
    output cache_pkg::index_t wr_index,
    output cache_pkg::strb_t  wr_strb,
    output cache_pkg::word_t  wr_data,
    output logic              hazard
);

    cache_pkg::sbuf_state_t state;

    // a fresh load keeps it in write for one more cycle
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= cache_pkg::sbuf_idle;
        end else begin
            case (state)
                cache_pkg::sbuf_idle:  state <= load ? cache_pkg::sbuf_write : cache_pkg::sbuf_idle;
                cache_pkg::sbuf_write: state <= load ? cache_pkg::sbuf_write : cache_pkg::sbuf_idle;
                default:               state <= cache_pkg::sbuf_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            wr_way   <= way;
            wr_bank  <= bank;
            wr_index <= index;
            wr_strb  <= strb;
            wr_data  <= wdata;
        end
    end

    assign wr_en  = (state == cache_pkg::sbuf_write);
    assign hazard = wr_en && req_valid && (req_op == cache_pkg::OP_READ) && (req_bank == wr_bank);

endmodule

/* hdl/tagv_array.sv */
// tag, valid and dirty storage
`timescale 1ns/1ps

module tagv_array (
    input  logic                   clk,
    input  logic                   resetn,
    input  cache_pkg::index_t      index,
    input  logic                   en,
    input  logic [1:0]             we,
    input  cache_pkg::tagv_t       wdata,
    input  logic                   dirty_set,
    input  cache_pkg::way_t        dirty_way,
    input  cache_pkg::index_t      dirty_index,
    input  logic                   dirty_clear,
    input  cache_pkg::way_t        clear_way,
    output cache_pkg::tagv_t [1:0] tagv,
    output logic [1:0]             dirty
);

    cache_pkg::tag_t                 tag_ram [2][cache_pkg::SETS];
    cache_pkg::tag_t [1:0]           tag_q;
    logic [1:0][cache_pkg::SETS-1:0] valid_q;
    logic [1:0][cache_pkg::SETS-1:0] dirty_q;
    logic [1:0]                      vld_q;
    cache_pkg::index_t               index_q;    // last read index, also picks the dirty bits

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (en) begin
                tag_q[w] <= tag_ram[w][index];    // read old value on a write
                if (we[w])
                    tag_ram[w][index] <= wdata[$bits(cache_pkg::tagv_t)-1:1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q <= '0;
            dirty_q <= '0;
            vld_q   <= '0;
            index_q <= '0;
        end else begin
            if (en) begin
                index_q <= index;
                for (int w = 0; w < 2; w++) begin
                    vld_q[w] <= valid_q[w][index];
                    if (we[w])
                        valid_q[w][index] <= wdata[0];
                end
            end
            if (dirty_set)
                dirty_q[dirty_way][dirty_index] <= 1'b1;
            if (dirty_clear)
                dirty_q[clear_way][index] <= 1'b0;    // line refilled from memory
        end
    end

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            tagv[w]  = {tag_q[w], vld_q[w]};
            dirty[w] = dirty_q[w][index_q];
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build the data cache testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sources.f --top-module cache_tb -o cache_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/cache_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi
exit 1

/* sources.f */
hdl/cache_pkg.sv
hdl/store_buffer.sv
hdl/tagv_array.sv
hdl/data_array.sv
hdl/cache_ctrl.sv
hdl/cache_top.sv
verification/tb_clock.sv
verification/cache_tb.sv

/* verification/cache_tb.sv */
// data cache testbench
`timescale 1ns/1ps

module cache_tb;

    localparam int NUM_REQ     = 3000;
    localparam int MAX_CYCLES  = 200000;
    localparam int DRAIN_LIMIT = 1000;
    localparam int K_READ      = 0;
    localparam int K_RAW       = 1;    // read issued right after a store
    localparam int K_STORE     = 2;

    logic               clk;
    logic               resetn;
    logic               valid;
    logic               op;
    cache_pkg::index_t  index;
    cache_pkg::tag_t    tag;
    cache_pkg::offset_t offset;
    cache_pkg::strb_t   wstrb;
    cache_pkg::word_t   wdata;
    logic               addr_ok;
    logic               data_ok;
    cache_pkg::word_t   rdata;
    logic               rd_req;
    logic [2:0]         rd_type;
    cache_pkg::addr_t   rd_addr;
    logic               rd_rdy;
    logic               ret_valid;
    logic               ret_last;
    cache_pkg::word_t   ret_data;
    logic               wr_req;
    logic [2:0]         wr_type;
    cache_pkg::addr_t   wr_addr;
    cache_pkg::line_t   wr_data;
    logic               wr_rdy;

    integer             seed;
    int                 errors;
    int                 issued;
    int                 reads_checked;
    int                 stores_done;
    int                 write_backs;
    int                 refills;
    int                 cycles;
    int                 beat;
    logic               timed_out;
    logic               req_taken;
    logic               raw_follow;
    logic               last_store;
    logic               refill_active;
    cache_pkg::addr_t   refill_addr;

    int                 pend_kind [$];                  // oldest request first
    cache_pkg::word_t   pend_exp [$];
    cache_pkg::word_t   model [cache_pkg::addr_t];      // newest value of each word
    cache_pkg::word_t   main_mem [cache_pkg::addr_t];

    tb_clock u_clock (.clk(clk));

    cache_top #(
        .LFSR_SEED(3'b111)
    ) dut (
        .clk, .resetn,
        .valid, .op, .index, .tag, .offset, .wstrb, .wdata,
        .addr_ok, .data_ok, .rdata,
        .rd_req, .rd_type, .rd_addr, .rd_rdy, .ret_valid, .ret_last, .ret_data,
        .wr_req, .wr_type, .wr_addr, .wr_data, .wr_rdy
    );

    function automatic int unsigned rand_below(int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic cache_pkg::word_t initial_word(cache_pkg::addr_t a);
        return cache_pkg::word_t'(a * 32'd3 + 32'd1);
    endfunction

    function automatic cache_pkg::word_t model_word(cache_pkg::addr_t a);
        if (model.exists(a))
            return model[a];
        return initial_word(a);
    endfunction

    function automatic cache_pkg::word_t mem_word(cache_pkg::addr_t a);
        if (main_mem.exists(a))
            return main_mem[a];
        return initial_word(a);
    endfunction

    function automatic cache_pkg::word_t byte_mask(cache_pkg::strb_t s);
        cache_pkg::word_t m;
        for (int i = 0; i < 4; i++)
            m[8*i +: 8] = {8{s[i]}};
        return m;
    endfunction

    task automatic check_equal(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (expected !== actual) begin
            $display("error %s: expected %0h, actual %0h", name, expected, actual);
            errors++;
        end
    endtask

    // 4 tags and 4 indices keep misses and evictions frequent
    task automatic make_request();
        if (last_store && rand_below(3) == 0) begin
            op         = cache_pkg::OP_READ;
            raw_follow = 1'b1;
            if (rand_below(2) == 0) begin    // same bank, maybe another line
                tag   = cache_pkg::tag_t'(32'h0a000 + rand_below(4) * 32'h913);
                index = cache_pkg::index_t'(rand_below(4) * 32'h45);
            end
        end else begin
            op         = (rand_below(2) == 0) ? cache_pkg::OP_READ : cache_pkg::OP_WRITE;
            raw_follow = 1'b0;
            tag        = cache_pkg::tag_t'(32'h0a000 + rand_below(4) * 32'h913);
            index      = cache_pkg::index_t'(rand_below(4) * 32'h45);
            offset     = {cache_pkg::bank_t'(rand_below(4)), 2'b00};
        end
        wstrb = cache_pkg::strb_t'(rand_below(16));
        wdata = $random(seed);
    endtask

    task automatic sample_edge();
        cache_pkg::addr_t a;
        cache_pkg::word_t mask;
        int               kind;
        cache_pkg::word_t exp;
        if (data_ok) begin
            if (pend_kind.size() == 0) begin
                $display("data_ok was raised with no request outstanding");
                errors++;
            end else begin
                kind = pend_kind.pop_front();
                exp  = pend_exp.pop_front();
                if (kind == K_STORE) begin
                    stores_done++;
                end else begin
                    check_equal((kind == K_RAW) ? "read_after_store" : "read", exp, rdata);
                    reads_checked++;
                end
            end
        end
        if (valid && addr_ok) begin
            a = {tag, index, offset};
            if (op == cache_pkg::OP_READ) begin
                pend_kind.push_back(raw_follow ? K_RAW : K_READ);
                pend_exp.push_back(model_word(a));
                last_store = 1'b0;
            end else begin
                mask     = byte_mask(wstrb);
                model[a] = (model_word(a) & ~mask) | (wdata & mask);
                pend_kind.push_back(K_STORE);
                pend_exp.push_back('0);
                last_store = 1'b1;
            end
            issued++;
            req_taken = 1'b1;
        end
        if (wr_req && wr_rdy) begin
            check_equal("wr_type", cache_pkg::WR_BLOCK, wr_type);
            check_equal("wr_addr_align", 4'h0, wr_addr[3:0]);
            for (int i = 0; i < 4; i++) begin
                a = {wr_addr[31:4], 4'h0} + cache_pkg::addr_t'(4 * i);
                check_equal("write_back_data", model_word(a), wr_data[32*i +: 32]);
                main_mem[a] = wr_data[32*i +: 32];   // memory only, model unchanged
            end
            write_backs++;
        end
        if (ret_valid) begin
            beat++;
            if (beat == 4) begin
                refill_active = 1'b0;
                beat          = 0;
            end
        end
        if (rd_req && rd_rdy) begin
            check_equal("rd_type", cache_pkg::RD_BLOCK, rd_type);
            check_equal("rd_addr_align", 4'h0, rd_addr[3:0]);
            refill_addr   = {rd_addr[31:4], 4'h0};
            refill_active = 1'b1;
            beat          = 0;
            refills++;
        end
    endtask

    task automatic drive_inputs();
        if (!valid || req_taken) begin
            if (issued < NUM_REQ && rand_below(8) != 0) begin
                make_request();
                valid = 1'b1;
            end else begin
                valid = 1'b0;
            end
        end
        req_taken = 1'b0;
        wr_rdy    = (rand_below(4) != 0);
        rd_rdy    = !refill_active && (rand_below(2) != 0);
        if (refill_active && rand_below(3) != 0) begin    // beats with random gaps
            ret_valid = 1'b1;
            ret_last  = (beat == 3);
            ret_data  = mem_word(refill_addr + cache_pkg::addr_t'(4 * beat));
        end else begin
            ret_valid = 1'b0;
            ret_last  = 1'b0;
            ret_data  = $random(seed);
        end
    endtask

    task automatic run_cycle();
        @(negedge clk);
        drive_inputs();
        @(posedge clk);
        sample_edge();
    endtask

    initial begin
        seed          = 32'he874_c6f6;
        errors        = 0;
        issued        = 0;
        reads_checked = 0;
        stores_done   = 0;
        write_backs   = 0;
        refills       = 0;
        cycles        = 0;
        beat          = 0;
        timed_out     = 1'b0;
        req_taken     = 1'b0;
        raw_follow    = 1'b0;
        last_store    = 1'b0;
        refill_active = 1'b0;
        refill_addr   = '0;
        resetn        = 1'b0;
        valid         = 1'b0;
        op            = cache_pkg::OP_READ;
        index         = '0;
        tag           = '0;
        offset        = '0;
        wstrb         = '0;
        wdata         = '0;
        rd_rdy        = 1'b0;
        ret_valid     = 1'b0;
        ret_last      = 1'b0;
        ret_data      = '0;
        wr_rdy        = 1'b0;

        repeat (8) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        @(posedge clk);
        check_equal("reset_addr_ok", 1'b1, addr_ok);    // idle, nothing requested yet
        check_equal("reset_data_ok", 1'b0, data_ok);
        check_equal("reset_rd_req", 1'b0, rd_req);
        check_equal("reset_wr_req", 1'b0, wr_req);

        while (issued < NUM_REQ && !timed_out) begin
            run_cycle();
            cycles++;
            if (cycles >= MAX_CYCLES) begin
                $display("timeout: only %0d of %0d requests were accepted", issued, NUM_REQ);
                timed_out = 1'b1;
            end
        end

        cycles = 0;
        while (pend_kind.size() != 0 && !timed_out) begin
            run_cycle();
            cycles++;
            if (cycles >= DRAIN_LIMIT) begin
                $display("timeout: %0d requests were never answered", pend_kind.size());
                timed_out = 1'b1;
            end
        end

        $display("errors %0d, reads %0d, stores %0d, write-backs %0d, refills %0d",
                 errors, reads_checked, stores_done, write_backs, refills);
        if (errors == 0 && !timed_out)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* verification/tb_clock.sv */
// testbench clock source
`timescale 1ns/1ps

module tb_clock #(
    parameter int HALF_PERIOD = 50    // ns
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule
